// ==== source/lsu_cfg_pkg.sv ====
// Data, address, byte-enable and ROB tag widths with their vector types
`default_nettype none

package lsu_cfg_pkg;

  // Data word and physical address
  localparam int unsigned XLEN = 32;
  localparam int unsigned PLEN = 32;

  // Byte lanes within one word
  localparam int unsigned BE_W = XLEN / 8;
  localparam int unsigned OFF_W = 2;

  // Reorder-buffer tag
  localparam int unsigned ROB_W = 6;

  typedef logic [XLEN-1:0] xlen_t;
  typedef logic [PLEN-1:0] addr_t;
  typedef logic [BE_W-1:0] be_t;
  typedef logic [ROB_W-1:0] rob_tag_t;

endpackage

`default_nettype wire

// ==== source/lsu_op_pkg.sv ====
// Memory operation codes, byte masks, store alignment and load extraction
`default_nettype none

package lsu_op_pkg;
  import lsu_cfg_pkg::*;

  typedef enum logic [3:0] {LB, LBU, LH, LHU, LW, SB, SH, SW} mem_op_e;

  function automatic logic is_store_op(input mem_op_e op);
    return op inside {SB, SH, SW};
  endfunction

  // Upper bytes fall off the word end
  function automatic be_t span_be(input be_t width, input logic [OFF_W-1:0] off);
    return width << off;
  endfunction

  function automatic be_t load_be(input mem_op_e op, input logic [OFF_W-1:0] off);
    case (op)
      LB, LBU: return span_be(4'b0001, off);
      LH, LHU: return span_be(4'b0011, off);
      LW:      return span_be(4'b1111, off);
      default: return '0;
    endcase
  endfunction

  function automatic be_t store_be(input mem_op_e op, input logic [OFF_W-1:0] off);
    case (op)
      SB:      return span_be(4'b0001, off);
      SH:      return span_be(4'b0011, off);
      SW:      return span_be(4'b1111, off);
      default: return '0;
    endcase
  endfunction

  function automatic xlen_t align_store(input mem_op_e op, input xlen_t data,
                                        input logic [OFF_W-1:0] off);
    xlen_t mask;
    be_t be;
    be = store_be(op, off);
    for (int b = 0; b < BE_W; b++) begin
      mask[8*b+:8] = {8{be[b]}};
    end
    return (data << (8 * off)) & mask;
  endfunction

  function automatic xlen_t extract_load(input mem_op_e op, input xlen_t word,
                                         input logic [OFF_W-1:0] off);
    xlen_t sh;
    sh = word >> (8 * off);
    case (op)
      LB:      return {{(XLEN - 8){sh[7]}}, sh[7:0]};
      LBU:     return {{(XLEN - 8){1'b0}}, sh[7:0]};
      LH:      return {{(XLEN - 16){sh[15]}}, sh[15:0]};
      LHU:     return {{(XLEN - 16){1'b0}}, sh[15:0]};
      default: return sh;
    endcase
  endfunction

endpackage

`default_nettype wire

// ==== source/sq_port_if.sv ====
// Store-queue allocation and forwarding signals with agu, ctrl and queue modports
`timescale 1ns/1ps
`default_nettype none

interface sq_port_if
  import lsu_cfg_pkg::*;
();

  // Request side, from the address unit
  addr_t word_addr;
  xlen_t store_data;
  be_t   store_be;
  be_t   load_be;

  // Qualifiers from the allocator
  logic  alloc_valid;
  logic  fwd_valid;

  // Queue answers
  logic  full;
  logic  fwd_hit;
  xlen_t fwd_data;

  modport agu(output word_addr, store_data, store_be, load_be);
  modport ctrl(output alloc_valid, fwd_valid, input full);
  modport queue(
    input word_addr, store_data, store_be, load_be, alloc_valid, fwd_valid,
    output full, fwd_hit, fwd_data
  );

endinterface

`default_nettype wire

// ==== source/lsu_agu.sv ====
// Address unit with effective address, word address, byte masks and aligned store data
`timescale 1ns/1ps
`default_nettype none

module lsu_agu
  import lsu_cfg_pkg::*;
  import lsu_op_pkg::*;
(
  input  xlen_t   req_base_i,
  input  xlen_t   req_imm_i,
  input  xlen_t   req_data_i,
  input  mem_op_e req_op_i,
  sq_port_if.agu  sq
);

  xlen_t            eff_addr;
  logic [OFF_W-1:0] offset;

  assign eff_addr = req_base_i + req_imm_i;
  assign offset = eff_addr[OFF_W-1:0];

  // Queue entries and forwarding compare on whole words
  assign sq.word_addr = {eff_addr[PLEN-1:OFF_W], {OFF_W{1'b0}}};

  assign sq.store_be = store_be(req_op_i, offset);
  assign sq.load_be = load_be(req_op_i, offset);
  assign sq.store_data = align_store(req_op_i, req_data_i, offset);

endmodule

`default_nettype wire

// ==== source/store_queue.sv ====
// Circular store queue with youngest-match forwarding and head drain
`timescale 1ns/1ps
`default_nettype none

module store_queue
  import lsu_cfg_pkg::*;
#(
  parameter int unsigned SQ_DEPTH = 8
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     flush_i,
  sq_port_if.queue sq,
  input  logic     commit_i,
  output logic     drain_valid_o,
  output addr_t    drain_addr_o,
  output xlen_t    drain_data_o,
  output be_t      drain_be_o
);

  localparam int unsigned PTR_W = (SQ_DEPTH > 1) ? $clog2(SQ_DEPTH) : 1;

  typedef logic [PTR_W-1:0] ptr_t;
  typedef logic [PTR_W:0] cnt_t;

  addr_t addr_q[SQ_DEPTH];
  xlen_t data_q[SQ_DEPTH];
  be_t   be_q[SQ_DEPTH];
  ptr_t  head_q;
  ptr_t  tail_q;
  cnt_t  count_q;

  logic  match_found;
  be_t   match_be;
  xlen_t match_data;

  // ====================================================================
  // Pointers and occupancy
  // ====================================================================
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      head_q <= '0;
      tail_q <= '0;
      count_q <= '0;
    end else if (flush_i) begin
      head_q <= '0;
      tail_q <= '0;
      count_q <= '0;
    end else begin
      if (sq.alloc_valid) begin
        tail_q <= tail_q + 1'b1;
      end
      if (commit_i) begin
        head_q <= head_q + 1'b1;
      end
      count_q <= count_q + cnt_t'(sq.alloc_valid) - cnt_t'(commit_i);
    end
  end

  always_ff @(posedge clk_i) begin
    if (sq.alloc_valid) begin
      addr_q[tail_q] <= sq.word_addr;
      data_q[tail_q] <= sq.store_data;
      be_q[tail_q] <= sq.store_be;
    end
  end

  assign sq.full = (count_q == cnt_t'(SQ_DEPTH));

  // ====================================================================
  // Forwarding search
  // ====================================================================
  // Walks oldest to youngest so the last match is the youngest
  always_comb begin
    ptr_t idx;
    match_found = 1'b0;
    match_be = '0;
    match_data = '0;
    for (int i = 0; i < SQ_DEPTH; i++) begin
      idx = head_q + ptr_t'(i);
      if ({1'b0, ptr_t'(i)} < count_q && addr_q[idx] == sq.word_addr) begin
        match_found = 1'b1;
        match_be = be_q[idx];
        match_data = data_q[idx];
      end
    end
  end

  // Partial overlap with the youngest match counts as a miss
  assign sq.fwd_hit = sq.fwd_valid && match_found && ((match_be & sq.load_be) == sq.load_be);
  assign sq.fwd_data = match_data;

  assign drain_valid_o = (count_q != '0);
  assign drain_addr_o = addr_q[head_q];
  assign drain_data_o = data_q[head_q];
  assign drain_be_o = be_q[head_q];

  a_commit_not_empty : assert property (@(posedge clk_i) disable iff (!rst_ni)
    commit_i |-> drain_valid_o);

  a_alloc_not_full : assert property (@(posedge clk_i) disable iff (!rst_ni)
    sq.alloc_valid |-> !sq.full);

endmodule

`default_nettype wire

// ==== source/lsu_lane.sv ====
// Load/store lane FSM holding one micro-op until writeback
`timescale 1ns/1ps
`default_nettype none

module lsu_lane
  import lsu_cfg_pkg::*;
  import lsu_op_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     flush_i,
  input  logic     start_i,
  input  mem_op_e  req_op_i,
  input  rob_tag_t req_tag_i,
  input  addr_t    req_addr_i,
  input  logic     fwd_hit_i,
  input  xlen_t    fwd_data_i,
  output logic     busy_o,
  output logic     cache_req_o,
  output addr_t    cache_addr_o,
  input  logic     cache_gnt_i,
  input  logic     rsp_valid_i,
  input  xlen_t    rsp_data_i,
  input  logic     rsp_err_i,
  output logic     wb_valid_o,
  output rob_tag_t wb_tag_o,
  output xlen_t    wb_data_o,
  output logic     wb_exception_o,
  input  logic     wb_gnt_i
);

  typedef enum logic [1:0] {IDLE, MEM_REQ, MEM_WAIT, WRITEBACK} lane_state_e;

  lane_state_e state_q;
  lane_state_e state_d;
  mem_op_e     op_q;
  rob_tag_t    tag_q;
  addr_t       addr_q;
  xlen_t       data_q;
  logic        exc_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (start_i) begin
          // Stores and forwarded loads skip the cache
          state_d = (is_store_op(req_op_i) || fwd_hit_i) ? WRITEBACK : MEM_REQ;
        end
      end
      MEM_REQ: begin
        if (cache_gnt_i) begin
          state_d = MEM_WAIT;
        end
      end
      MEM_WAIT: begin
        if (rsp_valid_i) begin
          state_d = WRITEBACK;
        end
      end
      default: begin
        if (wb_gnt_i) begin
          state_d = IDLE;
        end
      end
    endcase
    if (flush_i) begin
      state_d = IDLE;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      op_q <= req_op_i;
      tag_q <= req_tag_i;
      addr_q <= req_addr_i;
      exc_q <= 1'b0;
      data_q <= is_store_op(req_op_i) ? '0 :
                extract_load(req_op_i, fwd_data_i, req_addr_i[OFF_W-1:0]);
    end else if (rsp_valid_i) begin
      exc_q <= rsp_err_i;
      data_q <= rsp_err_i ? '0 : extract_load(op_q, rsp_data_i, addr_q[OFF_W-1:0]);
    end
  end

  assign busy_o = (state_q != IDLE);
  assign cache_req_o = (state_q == MEM_REQ);
  assign cache_addr_o = addr_q;
  assign wb_valid_o = (state_q == WRITEBACK);
  assign wb_tag_o = tag_q;
  assign wb_data_o = data_q;
  assign wb_exception_o = exc_q;

  a_start_idle : assert property (@(posedge clk_i) disable iff (!rst_ni)
    start_i |-> state_q == IDLE);

endmodule

`default_nettype wire

// ==== source/lsu_ctrl.sv ====
// Lane allocator, cache-port and writeback arbiters, response routing
`timescale 1ns/1ps
`default_nettype none

module lsu_ctrl
  import lsu_op_pkg::*;
#(
  parameter int unsigned N_LSU     = 2,
  parameter int unsigned LANE_ID_W = 1
) (
  input  logic                 req_valid_i,
  input  mem_op_e              req_op_i,
  output logic                 req_ready_o,
  sq_port_if.ctrl              sq,
  input  logic [N_LSU-1:0]     lane_busy_i,
  input  logic [N_LSU-1:0]     lane_cache_req_i,
  input  logic [N_LSU-1:0]     lane_wb_valid_i,
  output logic [N_LSU-1:0]     lane_start_o,
  output logic [N_LSU-1:0]     lane_cache_gnt_o,
  output logic [N_LSU-1:0]     lane_rsp_valid_o,
  output logic [N_LSU-1:0]     lane_wb_gnt_o,
  input  logic                 ld_req_ready_i,
  input  logic                 ld_rsp_valid_i,
  input  logic [LANE_ID_W-1:0] ld_rsp_id_i,
  output logic                 ld_req_valid_o,
  output logic [LANE_ID_W-1:0] ld_req_sel_o,
  output logic [LANE_ID_W-1:0] ld_req_id_o,
  output logic                 ld_rsp_ready_o,
  output logic                 wb_valid_o,
  output logic [LANE_ID_W-1:0] wb_sel_o
);

  logic [N_LSU-1:0]     lane_waiting;
  logic [LANE_ID_W-1:0] free_sel;
  logic                 is_store;
  logic                 ld_block;
  logic                 wb_block;
  logic                 accept;

  // Fixed priority, lowest index wins
  function automatic logic [LANE_ID_W-1:0] lowest_index(input logic [N_LSU-1:0] vec);
    logic [LANE_ID_W-1:0] idx;
    idx = '0;
    for (int i = N_LSU - 1; i >= 0; i--) begin
      if (vec[i]) begin
        idx = LANE_ID_W'(i);
      end
    end
    return idx;
  endfunction

  assign lane_waiting = lane_busy_i & ~lane_cache_req_i & ~lane_wb_valid_i;
  assign free_sel = lowest_index(~lane_busy_i);
  assign ld_req_valid_o = |lane_cache_req_i;
  assign ld_req_sel_o = lowest_index(lane_cache_req_i);
  assign ld_req_id_o = ld_req_sel_o;
  assign wb_valid_o = |lane_wb_valid_i;
  assign wb_sel_o = lowest_index(lane_wb_valid_i);

  // A lower lane must not overtake a presented request or writeback
  assign ld_block = ld_req_valid_o && !ld_req_ready_i && (free_sel < ld_req_sel_o);
  assign wb_block = wb_valid_o && (free_sel < wb_sel_o);

  assign is_store = is_store_op(req_op_i);
  assign req_ready_o = !(&lane_busy_i) && !wb_block && (is_store ? !sq.full : !ld_block);
  assign accept = req_valid_i && req_ready_o;
  assign sq.alloc_valid = accept && is_store;
  assign sq.fwd_valid = accept && !is_store;

  assign ld_rsp_ready_o = lane_waiting[ld_rsp_id_i] && !(wb_valid_o && ld_rsp_id_i < wb_sel_o);

  always_comb begin
    lane_start_o = '0;
    lane_cache_gnt_o = '0;
    lane_rsp_valid_o = '0;
    lane_wb_gnt_o = '0;
    lane_start_o[free_sel] = accept;
    lane_cache_gnt_o[ld_req_sel_o] = ld_req_valid_o && ld_req_ready_i;
    lane_rsp_valid_o[ld_rsp_id_i] = ld_rsp_valid_i && ld_rsp_ready_o;
    lane_wb_gnt_o[wb_sel_o] = wb_valid_o;
  end

endmodule

`default_nettype wire

// ==== source/lsu_group_top.sv ====
// Load/store unit group top with address unit, store queue, control and lane array
`timescale 1ns/1ps
`default_nettype none

module lsu_group_top
  import lsu_cfg_pkg::*;
  import lsu_op_pkg::*;
#(
  parameter int unsigned N_LSU     = 2,
  parameter int unsigned SQ_DEPTH  = 8,
  localparam int unsigned LANE_ID_W = (N_LSU > 1) ? $clog2(N_LSU) : 1
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 flush_i,
  input  logic                 req_valid_i,
  output logic                 req_ready_o,
  input  mem_op_e              req_op_i,
  input  xlen_t                req_base_i,
  input  xlen_t                req_imm_i,
  input  xlen_t                req_data_i,
  input  rob_tag_t             req_tag_i,
  output logic                 ld_req_valid_o,
  input  logic                 ld_req_ready_i,
  output addr_t                ld_req_addr_o,
  output logic [LANE_ID_W-1:0] ld_req_id_o,
  input  logic                 ld_rsp_valid_i,
  input  logic [LANE_ID_W-1:0] ld_rsp_id_i,
  input  xlen_t                ld_rsp_data_i,
  input  logic                 ld_rsp_err_i,
  output logic                 ld_rsp_ready_o,
  output logic                 wb_valid_o,
  input  logic                 wb_ready_i,
  output rob_tag_t             wb_tag_o,
  output xlen_t                wb_data_o,
  output logic                 wb_exception_o,
  output logic                 drain_valid_o,
  output addr_t                drain_addr_o,
  output xlen_t                drain_data_o,
  output be_t                  drain_be_o,
  input  logic                 commit_i
);

  logic [N_LSU-1:0]     lane_busy;
  logic [N_LSU-1:0]     lane_cache_req;
  logic [N_LSU-1:0]     lane_wb_valid;
  logic [N_LSU-1:0]     lane_start;
  logic [N_LSU-1:0]     lane_cache_gnt;
  logic [N_LSU-1:0]     lane_rsp_valid;
  logic [N_LSU-1:0]     lane_wb_gnt;
  logic [N_LSU-1:0]     lane_wb_exc;
  addr_t                lane_cache_addr[N_LSU];
  rob_tag_t             lane_wb_tag[N_LSU];
  xlen_t                lane_wb_data[N_LSU];
  logic [LANE_ID_W-1:0] ld_req_sel;
  logic [LANE_ID_W-1:0] wb_sel;
  be_t                  req_be;
  logic [OFF_W-1:0]     req_off;
  addr_t                req_addr;

  sq_port_if sq ();

  lsu_agu u_agu (
    .req_base_i,
    .req_imm_i,
    .req_data_i,
    .req_op_i,
    .sq
  );

  store_queue #(
    .SQ_DEPTH(SQ_DEPTH)
  ) u_sq (
    .clk_i,
    .rst_ni,
    .flush_i,
    .sq,
    .commit_i,
    .drain_valid_o,
    .drain_addr_o,
    .drain_data_o,
    .drain_be_o
  );

  lsu_ctrl #(
    .N_LSU(N_LSU),
    .LANE_ID_W(LANE_ID_W)
  ) u_ctrl (
    .req_valid_i,
    .req_op_i,
    .req_ready_o,
    .sq,
    .lane_busy_i(lane_busy),
    .lane_cache_req_i(lane_cache_req),
    .lane_wb_valid_i(lane_wb_valid),
    .lane_start_o(lane_start),
    .lane_cache_gnt_o(lane_cache_gnt),
    .lane_rsp_valid_o(lane_rsp_valid),
    .lane_wb_gnt_o(lane_wb_gnt),
    .ld_req_ready_i,
    .ld_rsp_valid_i,
    .ld_rsp_id_i,
    .ld_req_valid_o,
    .ld_req_sel_o(ld_req_sel),
    .ld_req_id_o,
    .ld_rsp_ready_o,
    .wb_valid_o,
    .wb_sel_o(wb_sel)
  );

  // Byte offset recovered from the first enabled byte of either mask
  assign req_be = sq.load_be | sq.store_be;

  always_comb begin
    req_off = '0;
    for (int b = BE_W - 1; b >= 0; b--) begin
      if (req_be[b]) begin
        req_off = OFF_W'(b);
      end
    end
  end

  assign req_addr = {sq.word_addr[PLEN-1:OFF_W], req_off};

  // ====================================================================
  // Lane array
  // ====================================================================
  for (genvar i = 0; i < N_LSU; i++) begin : g_lane
    lsu_lane u_lane (
      .clk_i,
      .rst_ni,
      .flush_i,
      .start_i(lane_start[i]),
      .req_op_i,
      .req_tag_i,
      .req_addr_i(req_addr),
      .fwd_hit_i(sq.fwd_hit),
      .fwd_data_i(sq.fwd_data),
      .busy_o(lane_busy[i]),
      .cache_req_o(lane_cache_req[i]),
      .cache_addr_o(lane_cache_addr[i]),
      .cache_gnt_i(lane_cache_gnt[i]),
      .rsp_valid_i(lane_rsp_valid[i]),
      .rsp_data_i(ld_rsp_data_i),
      .rsp_err_i(ld_rsp_err_i),
      .wb_valid_o(lane_wb_valid[i]),
      .wb_tag_o(lane_wb_tag[i]),
      .wb_data_o(lane_wb_data[i]),
      .wb_exception_o(lane_wb_exc[i]),
      .wb_gnt_i(lane_wb_gnt[i] && wb_ready_i)
    );
  end

  // Steering for the selected lanes
  assign ld_req_addr_o = lane_cache_addr[ld_req_sel];
  assign wb_tag_o = lane_wb_tag[wb_sel];
  assign wb_data_o = lane_wb_data[wb_sel];
  assign wb_exception_o = lane_wb_exc[wb_sel];

  a_wb_hold : assert property (@(posedge clk_i) disable iff (!rst_ni || flush_i)
    wb_valid_o && !wb_ready_i |=> wb_valid_o && $stable(wb_tag_o) && $stable(wb_data_o));

  a_ld_req_hold : assert property (@(posedge clk_i) disable iff (!rst_ni || flush_i)
    ld_req_valid_o && !ld_req_ready_i |=> ld_req_valid_o && $stable(ld_req_addr_o)
      && $stable(ld_req_id_o));

endmodule

`default_nettype wire

// ==== verification/lsu_group_tb.sv ====
// Testbench for the load/store unit group with random stimulus, cache and memory model
`timescale 1ns/1ps
`default_nettype none

module lsu_group_tb
  import lsu_cfg_pkg::*;
  import lsu_op_pkg::*;
();

  localparam int N_LSU = 2;
  localparam int SQ_DEPTH = 8;
  localparam int ID_W = (N_LSU > 1) ? $clog2(N_LSU) : 1;
  localparam int ROUND_OPS = 200;
  localparam int N_OPS = 2 * ROUND_OPS;
  localparam int WATCHDOG_CYCLES = N_OPS * 40 + 10;
  localparam int MEM_BYTES = 512;
  localparam addr_t MEM_BASE = 32'h0000_0F00;
  localparam int KIND_STORE = 0;
  localparam int KIND_FWD = 1;
  localparam int KIND_MISS = 2;

  logic            clk_i;
  logic            rst_ni;
  logic            flush_i;
  logic            req_valid_i;
  logic            req_ready_o;
  mem_op_e         req_op_i;
  xlen_t           req_base_i;
  xlen_t           req_imm_i;
  xlen_t           req_data_i;
  rob_tag_t        req_tag_i;
  logic            ld_req_valid_o;
  logic            ld_req_ready_i;
  addr_t           ld_req_addr_o;
  logic [ID_W-1:0] ld_req_id_o;
  logic            ld_rsp_valid_i;
  logic [ID_W-1:0] ld_rsp_id_i;
  xlen_t           ld_rsp_data_i;
  logic            ld_rsp_err_i;
  logic            ld_rsp_ready_o;
  logic            wb_valid_o;
  logic            wb_ready_i;
  rob_tag_t        wb_tag_o;
  xlen_t           wb_data_o;
  logic            wb_exception_o;
  logic            drain_valid_o;
  addr_t           drain_addr_o;
  xlen_t           drain_data_o;
  be_t             drain_be_o;
  logic            commit_i;

  int seed = 8367;
  int mismatches;
  int failures;
  int issued;
  int issue_limit;
  int pend_count;
  logic issue_en;
  logic commit_en;
  logic flush_req;
  // Request driven and not yet accepted
  logic req_held;
  rob_tag_t next_tag;

  logic [7:0] mem[MEM_BYTES];

  // Store-queue mirror, oldest entry first
  addr_t sq_addr[$];
  xlen_t sq_data[$];
  be_t   sq_be[$];

  // Operations in flight, indexed by tag
  logic    pend_valid[64];
  mem_op_e pend_op[64];
  addr_t   pend_addr[64];
  int      pend_kind[64];
  xlen_t   pend_exp[64];
  int      pend_lane[64];

  // Lane occupancy and what the cache sent to each lane
  logic     lane_busy[N_LSU];
  rob_tag_t lane_tag[N_LSU];
  logic     lane_req_sent[N_LSU];
  logic     lane_rsp_seen[N_LSU];
  xlen_t    lane_word[N_LSU];
  logic     lane_err[N_LSU];

  // Cache model
  logic  rsp_wait[N_LSU];
  int    rsp_delay[N_LSU];
  addr_t rsp_addr[N_LSU];
  logic  rsp_active;

  lsu_group_top #(
    .N_LSU(N_LSU),
    .SQ_DEPTH(SQ_DEPTH)
  ) u_dut (
    .clk_i,
    .rst_ni,
    .flush_i,
    .req_valid_i,
    .req_ready_o,
    .req_op_i,
    .req_base_i,
    .req_imm_i,
    .req_data_i,
    .req_tag_i,
    .ld_req_valid_o,
    .ld_req_ready_i,
    .ld_req_addr_o,
    .ld_req_id_o,
    .ld_rsp_valid_i,
    .ld_rsp_id_i,
    .ld_rsp_data_i,
    .ld_rsp_err_i,
    .ld_rsp_ready_o,
    .wb_valid_o,
    .wb_ready_i,
    .wb_tag_o,
    .wb_data_o,
    .wb_exception_o,
    .drain_valid_o,
    .drain_addr_o,
    .drain_data_o,
    .drain_be_o,
    .commit_i
  );

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // ====================================================================
  // Reference rules
  // ====================================================================
  function automatic int roll(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  function automatic logic writes_memory(input mem_op_e op);
    return (op == SB) || (op == SH) || (op == SW);
  endfunction

  function automatic int access_size(input mem_op_e op);
    case (op)
      LB, LBU, SB: return 1;
      LH, LHU, SH: return 2;
      default:     return 4;
    endcase
  endfunction

  // Bytes from the offset up, none past the word end
  function automatic be_t byte_mask(input mem_op_e op, input int off);
    be_t m;
    m = '0;
    for (int b = 0; b < 4; b++) begin
      if (b >= off && b < off + access_size(op)) begin
        m[b] = 1'b1;
      end
    end
    return m;
  endfunction

  function automatic xlen_t place_store(input mem_op_e op, input xlen_t data, input int off);
    xlen_t w;
    be_t   m;
    w = '0;
    m = byte_mask(op, off);
    for (int b = 0; b < 4; b++) begin
      if (m[b]) begin
        w[8*b +: 8] = data[8*(b-off) +: 8];
      end
    end
    return w;
  endfunction

  function automatic xlen_t extend_load(input mem_op_e op, input xlen_t word, input int off);
    xlen_t v;
    int    size;
    logic  sign;
    v = '0;
    size = access_size(op);
    for (int k = 0; k < 4; k++) begin
      if (k < size && off + k < 4) begin
        v[8*k +: 8] = word[8*(off+k) +: 8];
      end
    end
    if (op == LB || op == LH) begin
      sign = v[8*size-1];
      for (int i = 8 * size; i < 32; i++) begin
        v[i] = sign;
      end
    end
    return v;
  endfunction

  // Initial contents mix every address byte
  function automatic logic [7:0] fill_byte(input addr_t a);
    return (a[7:0] * 8'd13) ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'hA5;
  endfunction

  function automatic int mem_index(input addr_t a);
    return int'(a - MEM_BASE);
  endfunction

  function automatic xlen_t read_word(input addr_t a);
    xlen_t w;
    int    base;
    base = mem_index({a[31:2], 2'b00});
    for (int b = 0; b < 4; b++) begin
      w[8*b +: 8] = mem[base + b];
    end
    return w;
  endfunction

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("Mismatch at %0t: %s: got %h, expected %h", $time, what, actual, expected);
      mismatches++;
    end
  endtask

  task automatic report_failure(input string what);
    $display("Error at %0t: %s", $time, what);
    failures++;
  endtask

  // ====================================================================
  // One clock cycle of checking and stimulus
  // ====================================================================
  task automatic cycle_step();
    logic     accepted;
    logic     all_busy;
    logic     hit;
    rob_tag_t t;
    int       l;
    int       off;
    xlen_t    fwd_word;
    be_t      lmask;
    addr_t    eff;
    @(posedge clk_i);

    check_value(32'(drain_valid_o), 32'(sq_addr.size() != 0), "drain valid");
    if (drain_valid_o && sq_addr.size() != 0) begin
      check_value(drain_addr_o, sq_addr[0], "drain address");
      check_value(drain_data_o, sq_data[0], "drain data");
      check_value(32'(drain_be_o), 32'(sq_be[0]), "drain byte enables");
    end

    all_busy = 1'b1;
    for (int i = 0; i < N_LSU; i++) begin
      all_busy &= lane_busy[i];
    end
    if (all_busy) begin
      check_value(32'(req_ready_o), 32'd0, "request ready with every lane busy");
    end

    if (ld_req_valid_o && ld_req_ready_i) begin
      l = int'(ld_req_id_o);
      t = lane_tag[l];
      if (!lane_busy[l] || lane_req_sent[l] || pend_kind[t] != KIND_MISS) begin
        report_failure($sformatf("cache request from lane %0d, which holds no missed load", l));
      end else begin
        check_value(ld_req_addr_o, pend_addr[t], "cache request address");
        lane_req_sent[l] = 1'b1;
        rsp_wait[l] = 1'b1;
        rsp_delay[l] = roll(6);
        rsp_addr[l] = pend_addr[t];
      end
    end

    if (ld_rsp_valid_i && ld_rsp_ready_o) begin
      l = int'(ld_rsp_id_i);
      if (!lane_req_sent[l] || lane_rsp_seen[l]) begin
        report_failure($sformatf("cache response taken by lane %0d, which was not waiting", l));
      end else begin
        lane_word[l] = ld_rsp_data_i;
        lane_err[l] = ld_rsp_err_i;
        lane_rsp_seen[l] = 1'b1;
      end
      rsp_active = 1'b0;
    end

    accepted = req_valid_i && req_ready_o;
    if (accepted) begin
      eff = req_base_i + req_imm_i;
      off = int'(eff[1:0]);
      t = req_tag_i;
      l = -1;
      for (int i = N_LSU - 1; i >= 0; i--) begin
        if (!lane_busy[i]) begin
          l = i;
        end
      end
      if (l < 0) begin
        report_failure("request accepted while every lane was busy");
      end else begin
        lane_busy[l] = 1'b1;
        lane_tag[l] = t;
        lane_req_sent[l] = 1'b0;
        lane_rsp_seen[l] = 1'b0;
        pend_valid[t] = 1'b1;
        pend_op[t] = req_op_i;
        pend_addr[t] = eff;
        pend_lane[t] = l;
        pend_count++;
        pend_kind[t] = KIND_STORE;
        if (!writes_memory(req_op_i)) begin
          // Youngest entry on the same word decides
          hit = 1'b0;
          fwd_word = '0;
          lmask = byte_mask(req_op_i, off);
          for (int e = 0; e < sq_addr.size(); e++) begin
            if (sq_addr[e] == {eff[31:2], 2'b00}) begin
              hit = ((sq_be[e] & lmask) == lmask);
              fwd_word = sq_data[e];
            end
          end
          pend_kind[t] = hit ? KIND_FWD : KIND_MISS;
          pend_exp[t] = extend_load(req_op_i, fwd_word, off);
        end
      end
    end

    if (flush_i) begin
      sq_addr.delete();
      sq_data.delete();
      sq_be.delete();
    end else if (commit_i && sq_addr.size() != 0) begin
      for (int b = 0; b < 4; b++) begin
        if (sq_be[0][b]) begin
          mem[mem_index(sq_addr[0]) + b] = sq_data[0][8*b +: 8];
        end
      end
      void'(sq_addr.pop_front());
      void'(sq_data.pop_front());
      void'(sq_be.pop_front());
    end
    if (accepted && !flush_i && writes_memory(req_op_i)) begin
      eff = req_base_i + req_imm_i;
      sq_addr.push_back({eff[31:2], 2'b00});
      sq_be.push_back(byte_mask(req_op_i, int'(eff[1:0])));
      sq_data.push_back(place_store(req_op_i, req_data_i, int'(eff[1:0])));
    end

    if (wb_valid_o && wb_ready_i) begin
      t = wb_tag_o;
      if (!pend_valid[t]) begin
        report_failure($sformatf("writeback for tag %0d with no operation in flight", t));
      end else begin
        l = pend_lane[t];
        if (pend_kind[t] == KIND_STORE) begin
          check_value(32'(wb_exception_o), 32'd0, "store exception flag");
        end else if (pend_kind[t] == KIND_FWD) begin
          check_value(32'(wb_exception_o), 32'd0, "forwarded load exception flag");
          check_value(wb_data_o, pend_exp[t], "forwarded load data");
        end else if (!lane_rsp_seen[l]) begin
          report_failure($sformatf("load tag %0d wrote back before its cache response", t));
        end else if (lane_err[l]) begin
          check_value(32'(wb_exception_o), 32'd1, "load exception flag after cache error");
        end else begin
          check_value(32'(wb_exception_o), 32'd0, "load exception flag");
          check_value(wb_data_o, extend_load(pend_op[t], lane_word[l],
                      int'(pend_addr[t][1:0])), "cache load data");
        end
        pend_valid[t] = 1'b0;
        pend_count--;
        lane_busy[l] = 1'b0;
      end
    end

    // Request held until it is accepted
    if (!req_valid_i || accepted) begin
      if (issue_en && issued < issue_limit && roll(4) != 0) begin
        req_valid_i <= 1'b1;
        req_op_i <= mem_op_e'(4'(roll(8)));
        req_base_i <= 32'h0000_1000 + 32'(roll(8) * 4);
        req_imm_i <= 32'(roll(7)) - 32'd3;
        req_data_i <= $random(seed);
        req_tag_i <= next_tag;
        next_tag = next_tag + 1'b1;
        req_held = 1'b1;
        issued++;
      end else begin
        req_valid_i <= 1'b0;
        req_held = 1'b0;
      end
    end

    ld_req_ready_i <= (roll(4) != 0);
    wb_ready_i <= (roll(3) != 0);
    commit_i <= commit_en && !commit_i && (sq_addr.size() != 0) && (roll(2) == 0);
    flush_i <= flush_req;

    if (!rsp_active) begin
      ld_rsp_valid_i <= 1'b0;
      for (int i = 0; i < N_LSU; i++) begin
        if (rsp_wait[i] && rsp_delay[i] > 0) begin
          rsp_delay[i]--;
        end else if (rsp_wait[i] && !rsp_active) begin
          rsp_wait[i] = 1'b0;
          rsp_active = 1'b1;
          ld_rsp_valid_i <= 1'b1;
          ld_rsp_id_i <= ID_W'(i);
          ld_rsp_data_i <= read_word(rsp_addr[i]);
          ld_rsp_err_i <= (roll(8) == 0);
        end
      end
    end
  endtask

  task automatic run_traffic(input int limit);
    issue_limit = limit;
    issue_en = 1'b1;
    commit_en = 1'b1;
    while (issued < limit) begin
      cycle_step();
    end
    issue_en = 1'b0;
    while (req_held) begin
      cycle_step();
    end
    // Stores stay queued while the lanes empty
    commit_en = 1'b0;
    while (pend_count != 0) begin
      cycle_step();
    end
  endtask

  initial begin : main
    rst_ni = 1'b0;
    flush_i = 1'b0;
    req_valid_i = 1'b0;
    req_op_i = LB;
    req_base_i = '0;
    req_imm_i = '0;
    req_data_i = '0;
    req_tag_i = '0;
    ld_req_ready_i = 1'b0;
    ld_rsp_valid_i = 1'b0;
    ld_rsp_id_i = '0;
    ld_rsp_data_i = '0;
    ld_rsp_err_i = 1'b0;
    wb_ready_i = 1'b0;
    commit_i = 1'b0;
    mismatches = 0;
    failures = 0;
    issued = 0;
    pend_count = 0;
    next_tag = '0;
    issue_en = 1'b0;
    commit_en = 1'b0;
    flush_req = 1'b0;
    req_held = 1'b0;
    rsp_active = 1'b0;
    for (int i = 0; i < MEM_BYTES; i++) begin
      mem[i] = fill_byte(MEM_BASE + addr_t'(i));
    end
    for (int i = 0; i < 64; i++) begin
      pend_valid[i] = 1'b0;
      pend_kind[i] = KIND_STORE;
    end
    for (int i = 0; i < N_LSU; i++) begin
      lane_busy[i] = 1'b0;
      lane_req_sent[i] = 1'b0;
      lane_rsp_seen[i] = 1'b0;
      rsp_wait[i] = 1'b0;
      rsp_delay[i] = 0;
    end

    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);
    check_value(32'(ld_req_valid_o), 32'd0, "cache request valid after reset");
    check_value(32'(ld_rsp_ready_o), 32'd0, "cache response ready after reset");
    check_value(32'(wb_valid_o), 32'd0, "writeback valid after reset");
    check_value(32'(drain_valid_o), 32'd0, "drain valid after reset");

    run_traffic(ROUND_OPS);

    // Flush while stores remain queued
    flush_req = 1'b1;
    cycle_step();
    flush_req = 1'b0;
    cycle_step();
    cycle_step();

    run_traffic(N_OPS);
    commit_en = 1'b1;
    while (sq_addr.size() != 0) begin
      cycle_step();
    end
    cycle_step();

    $display("Done: %0d operations, %0d mismatches, %0d other errors",
             issued, mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("Watchdog expired after %0d cycles: %0d mismatches, %0d other errors",
             WATCHDOG_CYCLES, mismatches, failures);
    $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
source/lsu_cfg_pkg.sv
source/lsu_op_pkg.sv
source/sq_port_if.sv
source/lsu_agu.sv
source/store_queue.sv
source/lsu_lane.sv
source/lsu_ctrl.sv
source/lsu_group_top.sv
verification/lsu_group_tb.sv

// ==== Makefile ====
# Verilator build and run for the load/store unit group testbench

VERILATOR ?= verilator
TOP       ?= lsu_group_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall
PASS_MSG  ?= All tests passed!

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
